//--- Bender.yml
package:
  name: openmips

export_include_dirs:
  - logic

sources:
  - logic/openmips_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/regfile.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/openmips.sv
  - target: test
    files:
      - verification/openmips_assertions.sv
      - verification/openmips_tb.sv

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`include "openmips_settings.svh"

module decode_stage import openmips_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [`ADDR_WIDTH-1:0]     pc_i,
    input  logic [`INST_WIDTH-1:0]     inst_i,
    input  logic [`DATA_WIDTH-1:0]     rdata1_i,
    input  logic [`DATA_WIDTH-1:0]     rdata2_i,
    output logic [`REG_ADDR_WIDTH-1:0] raddr1_o,
    output logic [`REG_ADDR_WIDTH-1:0] raddr2_o,
    output logic                       re1_o,
    output logic                       re2_o,
    output logic                       stall_o,
    output logic                       branch_taken_o,
    output logic [`ADDR_WIDTH-1:0]     branch_target_o,
    output id_ex_t                     id_ex_o
);
    opcode_t                opcode;
    funct_t                 funct;
    logic [`DATA_WIDTH-1:0] imm_zext;
    logic [`DATA_WIDTH-1:0] imm_sext;
    logic [`DATA_WIDTH-1:0] imm;
    logic                   use_imm;
    logic                   is_branch;
    logic                   branch_ne;
    id_ex_t                 id_ex_d;

    assign opcode   = opcode_t'(inst_i[`OPCODE_RANGE]);
    assign funct    = funct_t'(inst_i[`FUNCT_RANGE]);
    assign imm_zext = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, inst_i[`IMM_RANGE]};
    assign imm_sext = {{(`DATA_WIDTH-`IMM_WIDTH){inst_i[`IMM_WIDTH-1]}}, inst_i[`IMM_RANGE]};
    assign raddr1_o = inst_i[`RS_RANGE];
    assign raddr2_o = inst_i[`RT_RANGE];

    always_comb begin
        id_ex_d.alu_op = ALU_ADD;
        id_ex_d.mem_op = MEM_NONE;
        id_ex_d.waddr  = inst_i[`RT_RANGE];
        id_ex_d.we     = 1'b0;
        re1_o          = 1'b0;
        re2_o          = 1'b0;
        use_imm        = 1'b1;
        imm            = imm_sext;
        is_branch      = 1'b0;
        branch_ne      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                re1_o         = 1'b1;
                re2_o         = 1'b1;
                use_imm       = 1'b0;
                id_ex_d.waddr = inst_i[`RD_RANGE];
                id_ex_d.we    = 1'b1;
                case (funct)
                    FN_ADDU: id_ex_d.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_d.alu_op = ALU_SUB;
                    FN_AND:  id_ex_d.alu_op = ALU_AND;
                    FN_OR:   id_ex_d.alu_op = ALU_OR;
                    FN_XOR:  id_ex_d.alu_op = ALU_XOR;
                    FN_SLT:  id_ex_d.alu_op = ALU_SLT;
                    default: id_ex_d.we = 1'b0;  // nop and unsupported
                endcase
            end
            OP_ORI: begin
                re1_o          = 1'b1;
                imm            = imm_zext;
                id_ex_d.alu_op = ALU_OR;
                id_ex_d.we     = 1'b1;
            end
            OP_ADDIU: begin
                re1_o      = 1'b1;
                id_ex_d.we = 1'b1;
            end
            OP_LUI: begin
                imm            = imm_zext;
                id_ex_d.alu_op = ALU_LUI;
                id_ex_d.we     = 1'b1;
            end
            OP_LW: begin
                re1_o          = 1'b1;
                id_ex_d.mem_op = MEM_LOAD;
                id_ex_d.we     = 1'b1;
            end
            OP_SW: begin
                re1_o          = 1'b1;
                re2_o          = 1'b1;  // store data
                id_ex_d.mem_op = MEM_STORE;
            end
            OP_BEQ, OP_BNE: begin
                re1_o     = 1'b1;
                re2_o     = 1'b1;
                is_branch = 1'b1;
                branch_ne = (opcode == OP_BNE);
            end
            default: ;
        endcase
        id_ex_d.op1        = rdata1_i;
        id_ex_d.op2        = use_imm ? imm : rdata2_i;
        id_ex_d.store_data = rdata2_i;
    end

    assign branch_taken_o  = is_branch && ((rdata1_i == rdata2_i) != branch_ne);
    // relative to the delay slot pc
    assign branch_target_o = pc_i + `ADDR_WIDTH'(4) + {imm_sext[`ADDR_WIDTH-3:0], 2'b00};

    // load result not ready until memory stage
    assign stall_o = id_ex_o.we && (id_ex_o.mem_op == MEM_LOAD) &&
                     ((re1_o && raddr1_o == id_ex_o.waddr) ||
                      (re2_o && raddr2_o == id_ex_o.waddr));

    always_ff @(posedge clk) begin
        if (reset_i || stall_o) begin
            id_ex_o.mem_op <= MEM_NONE;  // bubble
            id_ex_o.we     <= 1'b0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`include "openmips_settings.svh"

module execute_stage import openmips_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  id_ex_t     id_ex_i,
    output reg_write_t ex_fwd_o,
    output ex_mem_t    ex_mem_o
);
    localparam int HALF = `DATA_WIDTH / 2;

    logic [`DATA_WIDTH-1:0] result;
    logic                   less;
    ex_mem_t                ex_mem_d;

    assign less = $signed(id_ex_i.op1) < $signed(id_ex_i.op2);

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: result = id_ex_i.op1 + id_ex_i.op2;  // wraps, no overflow trap
            ALU_SUB: result = id_ex_i.op1 - id_ex_i.op2;
            ALU_AND: result = id_ex_i.op1 & id_ex_i.op2;
            ALU_OR:  result = id_ex_i.op1 | id_ex_i.op2;
            ALU_XOR: result = id_ex_i.op1 ^ id_ex_i.op2;
            ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, less};
            ALU_LUI: result = {id_ex_i.op2[HALF-1:0], {HALF{1'b0}}};
            default: result = '0;
        endcase
    end

    // loads forward later, from the memory stage
    assign ex_fwd_o.we    = id_ex_i.we && (id_ex_i.mem_op != MEM_LOAD);
    assign ex_fwd_o.waddr = id_ex_i.waddr;
    assign ex_fwd_o.data  = result;

    assign ex_mem_d.mem_op     = id_ex_i.mem_op;
    assign ex_mem_d.result     = result;
    assign ex_mem_d.store_data = id_ex_i.store_data;
    assign ex_mem_d.waddr      = id_ex_i.waddr;
    assign ex_mem_d.we         = id_ex_i.we;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_mem_o.mem_op <= MEM_NONE;
            ex_mem_o.we     <= 1'b0;
        end else begin
            ex_mem_o <= ex_mem_d;
        end
    end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`include "openmips_settings.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   branch_taken_i,
    input  logic [`ADDR_WIDTH-1:0] branch_target_i,
    input  logic [`INST_WIDTH-1:0] rom_data_i,
    output logic                   rom_ce_o,
    output logic [`ADDR_WIDTH-1:0] rom_addr_o,
    output logic [`ADDR_WIDTH-1:0] id_pc_o,
    output logic [`INST_WIDTH-1:0] id_inst_o
);
    logic [`ADDR_WIDTH-1:0] pc_q;

    assign rom_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rom_ce_o <= 1'b0;
            pc_q     <= `RESET_PC;
        end else begin
            rom_ce_o <= 1'b1;  // first fetch in the cycle after reset
            if (rom_ce_o && !stall_i) begin
                pc_q <= branch_taken_i ? branch_target_i : pc_q + `ADDR_WIDTH'(4);
            end
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (reset_i || !rom_ce_o) begin
            id_pc_o   <= `RESET_PC;
            id_inst_o <= '0;  // sll r0, r0, 0
        end else if (!stall_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= rom_data_i;
        end
    end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps
`include "openmips_settings.svh"

module memory_stage import openmips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  ex_mem_t                ex_mem_i,
    input  logic [`DATA_WIDTH-1:0] ram_data_i,
    output logic                   ram_ce_o,
    output logic                   ram_we_o,
    output logic [`ADDR_WIDTH-1:0] ram_addr_o,
    output logic [`DATA_WIDTH-1:0] ram_wdata_o,
    output reg_write_t             mem_fwd_o,
    output reg_write_t             wb_o
);
    logic is_load;

    assign is_load = (ex_mem_i.mem_op == MEM_LOAD);

    // single-cycle strobe, ram never stalls
    assign ram_ce_o    = (ex_mem_i.mem_op != MEM_NONE);
    assign ram_we_o    = (ex_mem_i.mem_op == MEM_STORE);
    assign ram_addr_o  = ex_mem_i.result;
    assign ram_wdata_o = ex_mem_i.store_data;

    assign mem_fwd_o.we    = ex_mem_i.we;
    assign mem_fwd_o.waddr = ex_mem_i.waddr;
    assign mem_fwd_o.data  = is_load ? ram_data_i : ex_mem_i.result;

    // memory/write-back register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o.we <= 1'b0;
        end else begin
            wb_o <= mem_fwd_o;
        end
    end

endmodule

//--- logic/openmips.sv
`timescale 1ns/1ps
`include "openmips_settings.svh"

module openmips import openmips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`INST_WIDTH-1:0] rom_data_i,
    input  logic [`DATA_WIDTH-1:0] ram_data_i,
    output logic                   rom_ce_o,
    output logic [`ADDR_WIDTH-1:0] rom_addr_o,
    output logic                   ram_ce_o,
    output logic                   ram_we_o,
    output logic [`ADDR_WIDTH-1:0] ram_addr_o,
    output logic [`DATA_WIDTH-1:0] ram_wdata_o
);
    logic [`ADDR_WIDTH-1:0]     id_pc;
    logic [`INST_WIDTH-1:0]     id_inst;
    logic [`DATA_WIDTH-1:0]     rdata1;
    logic [`DATA_WIDTH-1:0]     rdata2;
    logic [`REG_ADDR_WIDTH-1:0] raddr1;
    logic [`REG_ADDR_WIDTH-1:0] raddr2;
    logic                       re1;
    logic                       re2;
    logic                       stall;
    logic                       branch_taken;
    logic [`ADDR_WIDTH-1:0]     branch_target;
    id_ex_t                     id_ex;
    ex_mem_t                    ex_mem;
    reg_write_t                 ex_fwd;
    reg_write_t                 mem_fwd;
    reg_write_t                 wb;

    fetch_stage fetch_stage_i (
        .clk(clk), .reset_i(reset_i),
        .stall_i(stall),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .rom_data_i(rom_data_i), .rom_ce_o(rom_ce_o), .rom_addr_o(rom_addr_o),
        .id_pc_o(id_pc), .id_inst_o(id_inst)
    );

    decode_stage decode_stage_i (
        .clk(clk), .reset_i(reset_i),
        .pc_i(id_pc), .inst_i(id_inst),
        .rdata1_i(rdata1), .rdata2_i(rdata2),
        .raddr1_o(raddr1), .raddr2_o(raddr2), .re1_o(re1), .re2_o(re2),
        .stall_o(stall),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .id_ex_o(id_ex)
    );

    regfile regfile_i (
        .clk(clk), .reset_i(reset_i),
        .wb_i(wb), .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd),
        .raddr1_i(raddr1), .raddr2_i(raddr2), .re1_i(re1), .re2_i(re2),
        .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    execute_stage execute_stage_i (
        .clk(clk), .reset_i(reset_i),
        .id_ex_i(id_ex), .ex_fwd_o(ex_fwd), .ex_mem_o(ex_mem)
    );

    memory_stage memory_stage_i (
        .clk(clk), .reset_i(reset_i),
        .ex_mem_i(ex_mem), .ram_data_i(ram_data_i),
        .ram_ce_o(ram_ce_o), .ram_we_o(ram_we_o),
        .ram_addr_o(ram_addr_o), .ram_wdata_o(ram_wdata_o),
        .mem_fwd_o(mem_fwd), .wb_o(wb)
    );

endmodule

//--- logic/openmips_pkg.sv
`include "openmips_settings.svh"

package openmips_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,  // must stay zero, bubbles rely on it
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    typedef struct packed {
        logic                       we;
        logic [`REG_ADDR_WIDTH-1:0] waddr;
        logic [`DATA_WIDTH-1:0]     data;
    } reg_write_t;

    typedef struct packed {
        alu_op_t                    alu_op;
        logic [`DATA_WIDTH-1:0]     op1;
        logic [`DATA_WIDTH-1:0]     op2;
        logic [`DATA_WIDTH-1:0]     store_data;
        mem_op_t                    mem_op;
        logic [`REG_ADDR_WIDTH-1:0] waddr;
        logic                       we;
    } id_ex_t;

    typedef struct packed {
        mem_op_t                    mem_op;
        logic [`DATA_WIDTH-1:0]     result;  // alu value or memory address
        logic [`DATA_WIDTH-1:0]     store_data;
        logic [`REG_ADDR_WIDTH-1:0] waddr;
        logic                       we;
    } ex_mem_t;

endpackage

//--- logic/openmips_settings.svh
`ifndef OPENMIPS_SETTINGS_SVH
`define OPENMIPS_SETTINGS_SVH

`define DATA_WIDTH      32
`define ADDR_WIDTH      32
`define INST_WIDTH      32
`define REG_COUNT       32
`define REG_ADDR_WIDTH  5
`define RESET_PC        32'h0000_0000

// instruction field positions
`define OPCODE_RANGE    31:26
`define RS_RANGE        25:21
`define RT_RANGE        20:16
`define RD_RANGE        15:11
`define FUNCT_RANGE     5:0
`define IMM_RANGE       15:0
`define IMM_WIDTH       16

`endif

//--- logic/regfile.sv
`timescale 1ns/1ps
`include "openmips_settings.svh"

module regfile import openmips_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_i,
    input  reg_write_t                 wb_i,
    input  reg_write_t                 ex_fwd_i,
    input  reg_write_t                 mem_fwd_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    input  logic                       re1_i,
    input  logic                       re2_i,
    output logic [`DATA_WIDTH-1:0]     rdata1_o,
    output logic [`DATA_WIDTH-1:0]     rdata2_o
);
    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!reset_i && wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.data;
        end
    end

    // youngest producer wins
    function automatic logic [`DATA_WIDTH-1:0] read_port(
        input logic [`REG_ADDR_WIDTH-1:0] addr,
        input logic                       re
    );
        if (!re || addr == '0) begin
            return '0;
        end
        if (ex_fwd_i.we && ex_fwd_i.waddr == addr) begin
            return ex_fwd_i.data;
        end
        if (mem_fwd_i.we && mem_fwd_i.waddr == addr) begin
            return mem_fwd_i.data;
        end
        if (wb_i.we && wb_i.waddr == addr) begin
            return wb_i.data;  // lands at this edge
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i, re1_i);
        rdata2_o = read_port(raddr2_i, re2_i);
    end

endmodule

//--- openmips.f
+incdir+logic
logic/openmips_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/regfile.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/openmips.sv
verification/openmips_assertions.sv
verification/openmips_tb.sv

//--- verification/openmips_assertions.sv
`timescale 1ns/1ps

module openmips_assertions (
    input logic        clk,
    input logic        reset_i,
    input logic        rom_ce_i,
    input logic [31:0] rom_addr_i,
    input logic        ram_ce_i,
    input logic        ram_we_i,
    input logic [31:0] ram_addr_i
);
    int fail_count = 0;

    // first edge only clears the registers, so check from the second reset cycle on
    reset_quiet: assert property (@(posedge clk)
        reset_i ##1 reset_i |-> !rom_ce_i && !ram_ce_i && !ram_we_i)
        else begin
            $error("strobe active during reset");
            fail_count++;
        end

    we_needs_ce: assert property (@(posedge clk) disable iff (reset_i)
        ram_we_i |-> ram_ce_i)
        else begin
            $error("ram write without chip enable");
            fail_count++;
        end

    ram_aligned: assert property (@(posedge clk) disable iff (reset_i)
        ram_ce_i |-> ram_addr_i[1:0] == 2'b00)
        else begin
            $error("unaligned data address");
            fail_count++;
        end

    rom_aligned: assert property (@(posedge clk) disable iff (reset_i)
        rom_addr_i[1:0] == 2'b00)
        else begin
            $error("unaligned fetch address");
            fail_count++;
        end

endmodule

//--- verification/openmips_tb.sv
`timescale 1ns/1ps
`include "openmips_settings.svh"

module openmips_tb import openmips_pkg::*; ();
    localparam int RESET_CYCLES   = 4;
    localparam int PROG_LEN       = 31;
    localparam int PIPE_DEPTH     = 5;
    localparam int TIMEOUT_CYCLES = 5 * (RESET_CYCLES + PROG_LEN + PIPE_DEPTH);
    localparam logic [15:0] LFSR_SEED  = 16'd22;
    localparam logic [15:0] ADDIU_IMM  = 16'hffff;

    logic                   clk;
    logic                   reset_i;
    logic [`INST_WIDTH-1:0] rom_data_i;
    logic [`DATA_WIDTH-1:0] ram_data_i;
    logic                   rom_ce_o;
    logic [`ADDR_WIDTH-1:0] rom_addr_o;
    logic                   ram_ce_o;
    logic                   ram_we_o;
    logic [`ADDR_WIDTH-1:0] ram_addr_o;
    logic [`DATA_WIDTH-1:0] ram_wdata_o;

    logic [31:0] rom [32];
    logic [31:0] ram [16];
    logic [15:0] lfsr;
    string       exp_name[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    int          cycle_count = 0;
    logic        stores_done = 1'b0;

    openmips openmips_i (.*);

    bind openmips openmips_assertions openmips_assertions_i (
        .clk(clk), .reset_i(reset_i),
        .rom_ce_i(rom_ce_o), .rom_addr_i(rom_addr_o),
        .ram_ce_i(ram_ce_o), .ram_we_i(ram_we_o), .ram_addr_i(ram_addr_o)
    );

    assign rom_data_i = rom_ce_o ? rom[rom_addr_o[6:2]] : '0;
    assign ram_data_i = ram[ram_addr_o[5:2]];  // combinational read

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic draw_bits(output logic [15:0] v);
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] rtype_word(input funct_t fn, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(input opcode_t op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic expect_store(input string name, input logic [31:0] addr,
                                input logic [31:0] data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : stimulus
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] t;
        logic [31:0] a32;
        logic [31:0] b32;
        reset_i = 1'b1;
        lfsr    = LFSR_SEED;
        draw_bits(a);
        draw_bits(b);
        while (a == b) begin
            draw_bits(b);
        end
        if (a < b) begin
            t = a;
            a = b;
            b = t;
        end
        a32 = {16'h0, a};
        b32 = {16'h0, b};
        foreach (rom[i]) rom[i] = '0;
        foreach (ram[i]) ram[i] = '0;
        rom[0]  = itype_word(OP_ORI, 5'd0, 5'd1, a);
        rom[1]  = itype_word(OP_ORI, 5'd0, 5'd2, b);
        rom[2]  = rtype_word(FN_ADDU, 5'd3, 5'd1, 5'd2);  // both operands forwarded
        rom[3]  = itype_word(OP_SW, 5'd0, 5'd3, 16'h00);
        rom[4]  = rtype_word(FN_SUBU, 5'd3, 5'd1, 5'd2);
        rom[5]  = itype_word(OP_SW, 5'd0, 5'd3, 16'h04);
        rom[6]  = rtype_word(FN_AND, 5'd3, 5'd1, 5'd2);
        rom[7]  = itype_word(OP_SW, 5'd0, 5'd3, 16'h08);
        rom[8]  = rtype_word(FN_OR, 5'd3, 5'd1, 5'd2);
        rom[9]  = itype_word(OP_SW, 5'd0, 5'd3, 16'h0c);
        rom[10] = rtype_word(FN_XOR, 5'd3, 5'd1, 5'd2);
        rom[11] = itype_word(OP_SW, 5'd0, 5'd3, 16'h10);
        rom[12] = rtype_word(FN_SLT, 5'd3, 5'd1, 5'd2);
        rom[13] = itype_word(OP_SW, 5'd0, 5'd3, 16'h14);
        rom[14] = itype_word(OP_ADDIU, 5'd1, 5'd7, ADDIU_IMM);
        rom[15] = itype_word(OP_SW, 5'd0, 5'd7, 16'h18);
        rom[16] = itype_word(OP_LUI, 5'd0, 5'd8, a);
        rom[17] = itype_word(OP_SW, 5'd0, 5'd8, 16'h1c);
        rom[18] = itype_word(OP_LW, 5'd0, 5'd4, 16'h00);
        rom[19] = rtype_word(FN_ADDU, 5'd5, 5'd4, 5'd4);  // load-use stall
        rom[20] = itype_word(OP_SW, 5'd0, 5'd5, 16'h20);
        rom[21] = itype_word(OP_BEQ, 5'd1, 5'd1, 16'd2);
        rom[22] = itype_word(OP_ORI, 5'd0, 5'd6, 16'd1);  // delay slot
        rom[23] = itype_word(OP_ORI, 5'd0, 5'd6, 16'd2);  // skipped
        rom[24] = itype_word(OP_SW, 5'd0, 5'd6, 16'h24);
        rom[25] = itype_word(OP_BNE, 5'd1, 5'd1, 16'd2);
        rom[26] = itype_word(OP_ORI, 5'd0, 5'd9, 16'd3);
        rom[27] = itype_word(OP_ORI, 5'd9, 5'd9, 16'd4);
        rom[28] = itype_word(OP_SW, 5'd0, 5'd9, 16'h28);
        rom[29] = itype_word(OP_BEQ, 5'd0, 5'd0, 16'hffff);  // spin here
        rom[30] = 32'h0;
        expect_store("addu", 32'h00, a32 + b32);
        expect_store("subu", 32'h04, a32 - b32);
        expect_store("and", 32'h08, a32 & b32);
        expect_store("or", 32'h0c, a32 | b32);
        expect_store("xor", 32'h10, a32 ^ b32);
        expect_store("slt", 32'h14, ($signed(a32) < $signed(b32)) ? 32'd1 : 32'd0);
        expect_store("addiu", 32'h18, a32 + {{16{ADDIU_IMM[15]}}, ADDIU_IMM});
        expect_store("lui", 32'h1c, {a, 16'h0});
        expect_store("load_use", 32'h20, (a32 + b32) + (a32 + b32));
        expect_store("beq_taken", 32'h24, 32'd1);
        expect_store("bne_untaken", 32'h28, 32'd7);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
    end

    always @(posedge clk) begin
        if (ram_ce_o && ram_we_o) begin
            ram[ram_addr_o[5:2]] <= ram_wdata_o;
        end
    end

    // stores must come in program order
    always @(posedge clk) begin
        if (!reset_i && ram_ce_o && ram_we_o) begin
            assert ({ram_addr_o, ram_wdata_o} == {exp_addr[0], exp_data[0]}) else begin
                $display("Error: %s expected addr %h data %h, actual addr %h data %h",
                         exp_name[0], exp_addr[0], exp_data[0], ram_addr_o, ram_wdata_o);
                $display("test failed");
                $fatal(1, "store check failed");
            end
            void'(exp_name.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            if (exp_addr.size() == 0) begin
                stores_done = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (openmips_i.openmips_assertions_i.fail_count != 0) begin
            $display("test failed");
            $fatal(1, "port protocol assertion failed on openmips");
        end else if (stores_done) begin
            $display("test passed");
            $finish;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("test failed");
            $fatal(1, "timeout after %0d cycles before the last store", cycle_count);
        end
    end

endmodule
